/* wired_isa_pkg.sv */
`default_nettype none

package wired_isa_pkg;

  // opcodes of the supported integer subset
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_ADDI = 3'd5,
    OP_MUL  = 3'd6
  } op_e;

  typedef logic [4:0] reg_id_t;

  typedef logic [31:0] data_t;

  // sign-extended for ADDI only
  localparam int IMM_W = 12;

endpackage

`default_nettype wire

/* wired_core_pkg.sv */
`default_nettype none

package wired_core_pkg;

  // execution unit that takes an instruction
  typedef enum logic {
    FU_ALU = 1'b0,
    FU_MUL = 1'b1
  } fu_e;

  localparam int ARCH_REGS = 32;

  // r0 reads as zero and is never renamed
  localparam logic [4:0] REG_ZERO = 5'd0;

endpackage

`default_nettype wire

/* wired_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module wired_regfile (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire wired_isa_pkg::reg_id_t raddr0_i,
  input  wire wired_isa_pkg::reg_id_t raddr1_i,
  output wired_isa_pkg::data_t       rdata0_o,
  output wired_isa_pkg::data_t       rdata1_o,
  input  wire logic                  we_i,
  input  wire wired_isa_pkg::reg_id_t waddr_i,
  input  wire wired_isa_pkg::data_t   wdata_i
);

  wired_isa_pkg::data_t regs_q [wired_core_pkg::ARCH_REGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < wired_core_pkg::ARCH_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != wired_core_pkg::REG_ZERO) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // rename covers same-cycle writes through the ROB lookup
  assign rdata0_o = regs_q[raddr0_i];
  assign rdata1_o = regs_q[raddr1_i];

endmodule

`default_nettype wire

/* wired_rename.sv */
`timescale 1ns/100ps
`default_nettype none

module wired_rename #(
  parameter int ROB_DEPTH = 8,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  input  wire logic                              pkg_valid_i,
  output logic                                   pkg_ready_o,
  input  wire wired_isa_pkg::op_e                pkg_op_i,
  input  wire wired_isa_pkg::reg_id_t            pkg_rd_i,
  input  wire wired_isa_pkg::reg_id_t            pkg_rs1_i,
  input  wire wired_isa_pkg::reg_id_t            pkg_rs2_i,
  input  wire logic [wired_isa_pkg::IMM_W-1:0]   pkg_imm_i,
  input  wire logic                              alloc_ready_i,
  input  wire logic [TAG_W-1:0]                  alloc_tag_i,
  output logic                                   alloc_valid_o,
  output wired_isa_pkg::reg_id_t                 alloc_rd_o,
  output logic [TAG_W-1:0]                       lk0_tag_o,
  input  wire logic                              lk0_done_i,
  input  wire wired_isa_pkg::data_t              lk0_data_i,
  output logic [TAG_W-1:0]                       lk1_tag_o,
  input  wire logic                              lk1_done_i,
  input  wire wired_isa_pkg::data_t              lk1_data_i,
  output wired_isa_pkg::reg_id_t                 rf_raddr0_o,
  output wired_isa_pkg::reg_id_t                 rf_raddr1_o,
  input  wire wired_isa_pkg::data_t              rf_rdata0_i,
  input  wire wired_isa_pkg::data_t              rf_rdata1_i,
  input  wire logic                              cdb_valid_i,
  input  wire logic [TAG_W-1:0]                  cdb_tag_i,
  input  wire wired_isa_pkg::data_t              cdb_data_i,
  input  wire logic                              ret_valid_i,
  input  wire wired_isa_pkg::reg_id_t            ret_rd_i,
  input  wire logic [TAG_W-1:0]                  ret_tag_i,
  input  wire logic                              disp_ready_i,
  output logic                                   rn_valid_o,
  output wired_isa_pkg::op_e                     rn_op_o,
  output logic [TAG_W-1:0]                       rn_tag_o,
  output wired_isa_pkg::data_t                   rn_a_o,
  output wired_isa_pkg::data_t                   rn_b_o,
  output logic                                   rn_a_rdy_o,
  output logic                                   rn_b_rdy_o,
  output logic [TAG_W-1:0]                       rn_a_tag_o,
  output logic [TAG_W-1:0]                       rn_b_tag_o
);

  // skid buffer holds the packet accepted during a stall
  logic                            skid_busy_q;
  wired_isa_pkg::op_e              skid_op_q;
  wired_isa_pkg::reg_id_t          skid_rd_q;
  wired_isa_pkg::reg_id_t          skid_rs1_q;
  wired_isa_pkg::reg_id_t          skid_rs2_q;
  logic [wired_isa_pkg::IMM_W-1:0] skid_imm_q;

  wired_isa_pkg::op_e              cur_op;
  wired_isa_pkg::reg_id_t          cur_rd;
  wired_isa_pkg::reg_id_t          cur_rs [2];
  logic [wired_isa_pkg::IMM_W-1:0] cur_imm;
  logic                            cur_valid;
  logic                            stage_free;
  logic                            fire;

  logic                            map_valid_q [wired_core_pkg::ARCH_REGS];
  logic [TAG_W-1:0]                map_tag_q   [wired_core_pkg::ARCH_REGS];

  logic                            src_mapped [2];
  logic [TAG_W-1:0]                src_tag    [2];
  logic                            src_rdy    [2];
  wired_isa_pkg::data_t            src_val    [2];
  logic                            lk_done    [2];
  wired_isa_pkg::data_t            lk_data    [2];
  wired_isa_pkg::data_t            rf_data    [2];

  logic                            rn_valid_q;
  logic                            rn_a_rdy_q;
  logic                            rn_b_rdy_q;
  wired_isa_pkg::data_t            rn_a_q;
  wired_isa_pkg::data_t            rn_b_q;

  assign pkg_ready_o = !skid_busy_q;
  assign cur_valid   = pkg_valid_i || skid_busy_q;
  assign cur_op      = skid_busy_q ? skid_op_q : pkg_op_i;
  assign cur_rd      = skid_busy_q ? skid_rd_q : pkg_rd_i;
  assign cur_rs[0]   = skid_busy_q ? skid_rs1_q : pkg_rs1_i;
  assign cur_rs[1]   = skid_busy_q ? skid_rs2_q : pkg_rs2_i;
  assign cur_imm     = skid_busy_q ? skid_imm_q : pkg_imm_i;

  assign stage_free = !rn_valid_q || disp_ready_i;
  assign fire       = cur_valid && alloc_ready_i && stage_free;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      skid_busy_q <= 1'b0;
    end else begin
      skid_busy_q <= cur_valid && !fire;
    end
  end

  always_ff @(posedge clk) begin
    if (!skid_busy_q) begin
      skid_op_q  <= pkg_op_i;
      skid_rd_q  <= pkg_rd_i;
      skid_rs1_q <= pkg_rs1_i;
      skid_rs2_q <= pkg_rs2_i;
      skid_imm_q <= pkg_imm_i;
    end
  end

  // map table; a new mapping wins over a retire clear of the same register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < wired_core_pkg::ARCH_REGS; i++) begin
        map_valid_q[i] <= 1'b0;
      end
    end else begin
      if (ret_valid_i && map_valid_q[ret_rd_i] && map_tag_q[ret_rd_i] == ret_tag_i) begin
        map_valid_q[ret_rd_i] <= 1'b0;
      end
      if (fire && cur_rd != wired_core_pkg::REG_ZERO) begin
        map_valid_q[cur_rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      map_tag_q[cur_rd] <= alloc_tag_i;
    end
  end

  assign lk_done[0] = lk0_done_i;
  assign lk_done[1] = lk1_done_i;
  assign lk_data[0] = lk0_data_i;
  assign lk_data[1] = lk1_data_i;
  assign rf_data[0] = rf_rdata0_i;
  assign rf_data[1] = rf_rdata1_i;

  // operands come from the register file, a finished ROB entry or this cycle's result bus
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      src_mapped[i] = map_valid_q[cur_rs[i]];
      src_tag[i]    = map_tag_q[cur_rs[i]];
      src_rdy[i]    = !src_mapped[i] || lk_done[i] ||
                      (cdb_valid_i && cdb_tag_i == src_tag[i]);
      if (!src_mapped[i]) begin
        src_val[i] = rf_data[i];
      end else if (lk_done[i]) begin
        src_val[i] = lk_data[i];
      end else begin
        src_val[i] = cdb_data_i;
      end
    end
    if (cur_op == wired_isa_pkg::OP_ADDI) begin
      src_rdy[1] = 1'b1;
      src_val[1] = {{($bits(wired_isa_pkg::data_t) - wired_isa_pkg::IMM_W)
                     {cur_imm[wired_isa_pkg::IMM_W-1]}}, cur_imm};
    end
  end

  assign lk0_tag_o     = src_tag[0];
  assign lk1_tag_o     = src_tag[1];
  assign rf_raddr0_o   = cur_rs[0];
  assign rf_raddr1_o   = cur_rs[1];
  assign alloc_valid_o = fire;
  assign alloc_rd_o    = cur_rd;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rn_valid_q <= 1'b0;
    end else if (stage_free) begin
      rn_valid_q <= fire;
    end
  end

  // while held, keep listening for the pending operands
  always_ff @(posedge clk) begin
    if (stage_free) begin
      if (fire) begin
        rn_op_o    <= cur_op;
        rn_tag_o   <= alloc_tag_i;
        rn_a_q     <= src_val[0];
        rn_b_q     <= src_val[1];
        rn_a_rdy_q <= src_rdy[0];
        rn_b_rdy_q <= src_rdy[1];
        rn_a_tag_o <= src_tag[0];
        rn_b_tag_o <= src_tag[1];
      end
    end else begin
      if (!rn_a_rdy_q && cdb_valid_i && cdb_tag_i == rn_a_tag_o) begin
        rn_a_q     <= cdb_data_i;
        rn_a_rdy_q <= 1'b1;
      end
      if (!rn_b_rdy_q && cdb_valid_i && cdb_tag_i == rn_b_tag_o) begin
        rn_b_q     <= cdb_data_i;
        rn_b_rdy_q <= 1'b1;
      end
    end
  end

  assign rn_valid_o = rn_valid_q;
  assign rn_a_o     = rn_a_q;
  assign rn_b_o     = rn_b_q;
  assign rn_a_rdy_o = rn_a_rdy_q;
  assign rn_b_rdy_o = rn_b_rdy_q;

  a_alloc_needs_room: assert property (@(posedge clk) disable iff (!rst_n)
    alloc_valid_o |-> alloc_ready_i);

endmodule

`default_nettype wire

/* wired_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

module wired_dispatch #(
  parameter int ROB_DEPTH   = 8,
  parameter int MUL_LATENCY = 3,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 rn_valid_i,
  input  wire wired_isa_pkg::op_e   rn_op_i,
  input  wire logic [TAG_W-1:0]     rn_tag_i,
  input  wire wired_isa_pkg::data_t rn_a_i,
  input  wire wired_isa_pkg::data_t rn_b_i,
  input  wire logic                 rn_a_rdy_i,
  input  wire logic                 rn_b_rdy_i,
  input  wire logic [TAG_W-1:0]     rn_a_tag_i,
  input  wire logic [TAG_W-1:0]     rn_b_tag_i,
  output logic                      disp_ready_o,
  input  wire logic                 cdb_valid_i,
  input  wire logic [TAG_W-1:0]     cdb_tag_i,
  input  wire wired_isa_pkg::data_t cdb_data_i,
  output logic                      alu_issue_o,
  output logic                      mul_issue_o,
  output wired_isa_pkg::op_e        iss_op_o,
  output logic [TAG_W-1:0]          iss_tag_o,
  output wired_isa_pkg::data_t      iss_a_o,
  output wired_isa_pkg::data_t      iss_b_o
);

  logic                valid_q;
  logic                a_rdy_q;
  logic                b_rdy_q;
  logic [TAG_W-1:0]    a_tag_q;
  logic [TAG_W-1:0]    b_tag_q;
  logic                load;
  logic                in_a_hit;
  logic                in_b_hit;
  logic                operands_ok;
  wired_core_pkg::fu_e fu;
  // mul_sr[k] is a multiplier issue k cycles ago
  logic [MUL_LATENCY-1:1] mul_sr_q;

  assign fu = (iss_op_o == wired_isa_pkg::OP_MUL) ? wired_core_pkg::FU_MUL
                                                   : wired_core_pkg::FU_ALU;
  assign operands_ok = valid_q && a_rdy_q && b_rdy_q;
  // an ALU issue now finishes together with the oldest multiply in flight
  assign alu_issue_o = operands_ok && fu == wired_core_pkg::FU_ALU &&
                       !mul_sr_q[MUL_LATENCY-1];
  assign mul_issue_o = operands_ok && fu == wired_core_pkg::FU_MUL;

  assign disp_ready_o = !valid_q || alu_issue_o || mul_issue_o;
  assign load         = rn_valid_i && disp_ready_o;
  assign in_a_hit     = cdb_valid_i && cdb_tag_i == rn_a_tag_i;
  assign in_b_hit     = cdb_valid_i && cdb_tag_i == rn_b_tag_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q  <= 1'b0;
      mul_sr_q <= '0;
    end else begin
      if (disp_ready_o) begin
        valid_q <= rn_valid_i;
      end
      mul_sr_q[1] <= mul_issue_o;
      for (int k = MUL_LATENCY - 1; k > 1; k--) begin
        mul_sr_q[k] <= mul_sr_q[k-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      iss_op_o  <= rn_op_i;
      iss_tag_o <= rn_tag_i;
      a_tag_q   <= rn_a_tag_i;
      b_tag_q   <= rn_b_tag_i;
      a_rdy_q   <= rn_a_rdy_i || in_a_hit;
      b_rdy_q   <= rn_b_rdy_i || in_b_hit;
      iss_a_o   <= rn_a_rdy_i ? rn_a_i : cdb_data_i;
      iss_b_o   <= rn_b_rdy_i ? rn_b_i : cdb_data_i;
    end else begin
      if (!a_rdy_q && cdb_valid_i && cdb_tag_i == a_tag_q) begin
        iss_a_o <= cdb_data_i;
        a_rdy_q <= 1'b1;
      end
      if (!b_rdy_q && cdb_valid_i && cdb_tag_i == b_tag_q) begin
        iss_b_o <= cdb_data_i;
        b_rdy_q <= 1'b1;
      end
    end
  end

  a_single_issue: assert property (@(posedge clk) disable iff (!rst_n)
    !(alu_issue_o && mul_issue_o));

endmodule

`default_nettype wire

/* wired_exec.sv */
`timescale 1ns/100ps
`default_nettype none

module wired_exec #(
  parameter int ROB_DEPTH   = 8,
  parameter int MUL_LATENCY = 3,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 alu_issue_i,
  input  wire logic                 mul_issue_i,
  input  wire wired_isa_pkg::op_e   iss_op_i,
  input  wire logic [TAG_W-1:0]     iss_tag_i,
  input  wire wired_isa_pkg::data_t iss_a_i,
  input  wire wired_isa_pkg::data_t iss_b_i,
  output logic                      cdb_valid_o,
  output logic [TAG_W-1:0]          cdb_tag_o,
  output wired_isa_pkg::data_t      cdb_data_o
);

  wired_isa_pkg::data_t alu_res;
  logic                 alu_v_q;
  logic [TAG_W-1:0]     alu_tag_q;
  wired_isa_pkg::data_t alu_res_q;
  logic                 mul_v_q   [MUL_LATENCY];
  logic [TAG_W-1:0]     mul_tag_q [MUL_LATENCY];
  wired_isa_pkg::data_t mul_p_q   [MUL_LATENCY];
  wired_core_pkg::fu_e  iss_fu;

  always_comb begin
    case (iss_op_i)
      wired_isa_pkg::OP_SUB: alu_res = iss_a_i - iss_b_i;
      wired_isa_pkg::OP_AND: alu_res = iss_a_i & iss_b_i;
      wired_isa_pkg::OP_OR:  alu_res = iss_a_i | iss_b_i;
      wired_isa_pkg::OP_XOR: alu_res = iss_a_i ^ iss_b_i;
      default:               alu_res = iss_a_i + iss_b_i;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      alu_v_q <= 1'b0;
      for (int s = 0; s < MUL_LATENCY; s++) begin
        mul_v_q[s] <= 1'b0;
      end
    end else begin
      alu_v_q    <= alu_issue_i;
      mul_v_q[0] <= mul_issue_i;
      for (int s = 1; s < MUL_LATENCY; s++) begin
        mul_v_q[s] <= mul_v_q[s-1];
      end
    end
  end

  // low word of the product; later stages only carry it along
  always_ff @(posedge clk) begin
    alu_tag_q    <= iss_tag_i;
    alu_res_q    <= alu_res;
    mul_tag_q[0] <= iss_tag_i;
    mul_p_q[0]   <= iss_a_i * iss_b_i;
    for (int s = 1; s < MUL_LATENCY; s++) begin
      mul_tag_q[s] <= mul_tag_q[s-1];
      mul_p_q[s]   <= mul_p_q[s-1];
    end
  end

  assign cdb_valid_o = alu_v_q || mul_v_q[MUL_LATENCY-1];
  assign cdb_tag_o   = alu_v_q ? alu_tag_q : mul_tag_q[MUL_LATENCY-1];
  assign cdb_data_o  = alu_v_q ? alu_res_q : mul_p_q[MUL_LATENCY-1];

  assign iss_fu = (iss_op_i == wired_isa_pkg::OP_MUL) ? wired_core_pkg::FU_MUL
                                                       : wired_core_pkg::FU_ALU;

  // dispatch routes each op to its own unit
  a_unit_matches_op: assert property (@(posedge clk) disable iff (!rst_n)
    (alu_issue_i || mul_issue_i) |-> (mul_issue_i == (iss_fu == wired_core_pkg::FU_MUL)));

  a_no_cdb_collision: assert property (@(posedge clk) disable iff (!rst_n)
    !(alu_v_q && mul_v_q[MUL_LATENCY-1]));

endmodule

`default_nettype wire

/* wired_rob.sv */
`timescale 1ns/100ps
`default_nettype none

module wired_rob #(
  parameter int ROB_DEPTH = 8,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   alloc_valid_i,
  input  wire wired_isa_pkg::reg_id_t alloc_rd_i,
  output logic                        alloc_ready_o,
  output logic [TAG_W-1:0]            alloc_tag_o,
  input  wire logic [TAG_W-1:0]       lk0_tag_i,
  output logic                        lk0_done_o,
  output wired_isa_pkg::data_t        lk0_data_o,
  input  wire logic [TAG_W-1:0]       lk1_tag_i,
  output logic                        lk1_done_o,
  output wired_isa_pkg::data_t        lk1_data_o,
  input  wire logic                   cdb_valid_i,
  input  wire logic [TAG_W-1:0]       cdb_tag_i,
  input  wire wired_isa_pkg::data_t   cdb_data_i,
  output logic                        ret_valid_o,
  output wired_isa_pkg::reg_id_t      ret_rd_o,
  output logic [TAG_W-1:0]            ret_tag_o,
  output wired_isa_pkg::data_t        ret_data_o
);

  logic                   busy_q [ROB_DEPTH];
  logic                   done_q [ROB_DEPTH];
  wired_isa_pkg::reg_id_t rd_q   [ROB_DEPTH];
  wired_isa_pkg::data_t   data_q [ROB_DEPTH];
  logic [TAG_W-1:0]       head_q;
  logic [TAG_W-1:0]       tail_q;
  logic [TAG_W:0]         count_q;

  assign alloc_ready_o = count_q != ROB_DEPTH[TAG_W:0];
  assign alloc_tag_o   = tail_q;

  // head retires as soon as its result is in
  assign ret_valid_o = busy_q[head_q] && done_q[head_q];
  assign ret_rd_o    = rd_q[head_q];
  assign ret_tag_o   = head_q;
  assign ret_data_o  = data_q[head_q];

  assign lk0_done_o = done_q[lk0_tag_i];
  assign lk0_data_o = data_q[lk0_tag_i];
  assign lk1_done_o = done_q[lk1_tag_i];
  assign lk1_data_o = data_q[lk1_tag_i];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      for (int i = 0; i < ROB_DEPTH; i++) begin
        busy_q[i] <= 1'b0;
        done_q[i] <= 1'b0;
      end
    end else begin
      if (cdb_valid_i) begin
        done_q[cdb_tag_i] <= 1'b1;
      end
      if (ret_valid_o) begin
        busy_q[head_q] <= 1'b0;
        done_q[head_q] <= 1'b0;
        head_q         <= head_q + 1'b1;
      end
      if (alloc_valid_i) begin
        busy_q[tail_q] <= 1'b1;
        done_q[tail_q] <= 1'b0;
        tail_q         <= tail_q + 1'b1;
      end
      count_q <= count_q + (TAG_W + 1)'(alloc_valid_i) - (TAG_W + 1)'(ret_valid_o);
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_valid_i) begin
      rd_q[tail_q] <= alloc_rd_i;
    end
    if (cdb_valid_i) begin
      data_q[cdb_tag_i] <= cdb_data_i;
    end
  end

  a_cdb_hits_busy: assert property (@(posedge clk) disable iff (!rst_n)
    cdb_valid_i |-> busy_q[cdb_tag_i]);

endmodule

`default_nettype wire

/* wired_backend.sv */
`timescale 1ns/100ps
`default_nettype none

module wired_backend #(
  parameter int ROB_DEPTH   = 8,
  parameter int MUL_LATENCY = 3
) (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic                            pkg_valid_i,
  output logic                                 pkg_ready_o,
  input  wire wired_isa_pkg::op_e              pkg_op_i,
  input  wire wired_isa_pkg::reg_id_t          pkg_rd_i,
  input  wire wired_isa_pkg::reg_id_t          pkg_rs1_i,
  input  wire wired_isa_pkg::reg_id_t          pkg_rs2_i,
  input  wire logic [wired_isa_pkg::IMM_W-1:0] pkg_imm_i,
  output logic                                 commit_valid_o,
  output wired_isa_pkg::reg_id_t               commit_rd_o,
  output wired_isa_pkg::data_t                 commit_data_o
);

  localparam int TAG_W = $clog2(ROB_DEPTH);

  logic alloc_ready, alloc_valid;
  logic [TAG_W-1:0] alloc_tag;
  wired_isa_pkg::reg_id_t alloc_rd;
  logic [TAG_W-1:0] lk0_tag, lk1_tag;
  logic lk0_done, lk1_done;
  wired_isa_pkg::data_t lk0_data, lk1_data;
  wired_isa_pkg::reg_id_t rf_raddr0, rf_raddr1;
  wired_isa_pkg::data_t rf_rdata0, rf_rdata1;
  logic cdb_valid;
  logic [TAG_W-1:0] cdb_tag;
  wired_isa_pkg::data_t cdb_data;
  logic ret_valid;
  wired_isa_pkg::reg_id_t ret_rd;
  logic [TAG_W-1:0] ret_tag;
  wired_isa_pkg::data_t ret_data;
  logic disp_ready, rn_valid, rn_a_rdy, rn_b_rdy;
  wired_isa_pkg::op_e rn_op, iss_op;
  logic [TAG_W-1:0] rn_tag, rn_a_tag, rn_b_tag, iss_tag;
  wired_isa_pkg::data_t rn_a, rn_b, iss_a, iss_b;
  logic alu_issue, mul_issue;

  wired_rename #(.ROB_DEPTH(ROB_DEPTH)) u_rename (
    .clk(clk), .rst_n(rst_n),
    .pkg_valid_i(pkg_valid_i), .pkg_ready_o(pkg_ready_o), .pkg_op_i(pkg_op_i),
    .pkg_rd_i(pkg_rd_i), .pkg_rs1_i(pkg_rs1_i), .pkg_rs2_i(pkg_rs2_i),
    .pkg_imm_i(pkg_imm_i),
    .alloc_ready_i(alloc_ready), .alloc_tag_i(alloc_tag),
    .alloc_valid_o(alloc_valid), .alloc_rd_o(alloc_rd),
    .lk0_tag_o(lk0_tag), .lk0_done_i(lk0_done), .lk0_data_i(lk0_data),
    .lk1_tag_o(lk1_tag), .lk1_done_i(lk1_done), .lk1_data_i(lk1_data),
    .rf_raddr0_o(rf_raddr0), .rf_raddr1_o(rf_raddr1),
    .rf_rdata0_i(rf_rdata0), .rf_rdata1_i(rf_rdata1),
    .cdb_valid_i(cdb_valid), .cdb_tag_i(cdb_tag), .cdb_data_i(cdb_data),
    .ret_valid_i(ret_valid), .ret_rd_i(ret_rd), .ret_tag_i(ret_tag),
    .disp_ready_i(disp_ready),
    .rn_valid_o(rn_valid), .rn_op_o(rn_op), .rn_tag_o(rn_tag),
    .rn_a_o(rn_a), .rn_b_o(rn_b), .rn_a_rdy_o(rn_a_rdy), .rn_b_rdy_o(rn_b_rdy),
    .rn_a_tag_o(rn_a_tag), .rn_b_tag_o(rn_b_tag)
  );

  wired_regfile u_regfile (
    .clk(clk), .rst_n(rst_n),
    .raddr0_i(rf_raddr0), .raddr1_i(rf_raddr1),
    .rdata0_o(rf_rdata0), .rdata1_o(rf_rdata1),
    .we_i(ret_valid), .waddr_i(ret_rd), .wdata_i(ret_data)
  );

  wired_dispatch #(.ROB_DEPTH(ROB_DEPTH), .MUL_LATENCY(MUL_LATENCY)) u_dispatch (
    .clk(clk), .rst_n(rst_n),
    .rn_valid_i(rn_valid), .rn_op_i(rn_op), .rn_tag_i(rn_tag),
    .rn_a_i(rn_a), .rn_b_i(rn_b), .rn_a_rdy_i(rn_a_rdy), .rn_b_rdy_i(rn_b_rdy),
    .rn_a_tag_i(rn_a_tag), .rn_b_tag_i(rn_b_tag), .disp_ready_o(disp_ready),
    .cdb_valid_i(cdb_valid), .cdb_tag_i(cdb_tag), .cdb_data_i(cdb_data),
    .alu_issue_o(alu_issue), .mul_issue_o(mul_issue), .iss_op_o(iss_op),
    .iss_tag_o(iss_tag), .iss_a_o(iss_a), .iss_b_o(iss_b)
  );

  wired_exec #(.ROB_DEPTH(ROB_DEPTH), .MUL_LATENCY(MUL_LATENCY)) u_exec (
    .clk(clk), .rst_n(rst_n),
    .alu_issue_i(alu_issue), .mul_issue_i(mul_issue), .iss_op_i(iss_op),
    .iss_tag_i(iss_tag), .iss_a_i(iss_a), .iss_b_i(iss_b),
    .cdb_valid_o(cdb_valid), .cdb_tag_o(cdb_tag), .cdb_data_o(cdb_data)
  );

  wired_rob #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
    .clk(clk), .rst_n(rst_n),
    .alloc_valid_i(alloc_valid), .alloc_rd_i(alloc_rd),
    .alloc_ready_o(alloc_ready), .alloc_tag_o(alloc_tag),
    .lk0_tag_i(lk0_tag), .lk0_done_o(lk0_done), .lk0_data_o(lk0_data),
    .lk1_tag_i(lk1_tag), .lk1_done_o(lk1_done), .lk1_data_o(lk1_data),
    .cdb_valid_i(cdb_valid), .cdb_tag_i(cdb_tag), .cdb_data_i(cdb_data),
    .ret_valid_o(ret_valid), .ret_rd_o(ret_rd), .ret_tag_o(ret_tag),
    .ret_data_o(ret_data)
  );

  assign commit_valid_o = ret_valid;
  assign commit_rd_o    = ret_rd;
  assign commit_data_o  = ret_data;

endmodule

`default_nettype wire

/* tb_wired_backend.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_wired_backend;

  localparam int ROB_DEPTH   = 8;
  localparam int MUL_LATENCY = 3;
  localparam int IMM_W       = wired_isa_pkg::IMM_W;

  localparam int MODE_MIXED = 0;
  localparam int MODE_DEP   = 1;
  localparam int MODE_MUL   = 2;

  localparam int N_MIXED = 300;
  localparam int N_DEP   = 200;
  localparam int N_MUL   = 150;
  localparam int RESET_CYCLES = 16;
  // generous per-packet budget plus reset, idle check and drain
  localparam int WATCHDOG_CYCLES = 40 * (N_MIXED + N_DEP + N_MUL) + RESET_CYCLES + 40;

  logic                            clk;
  logic                            rst_n;
  logic                            pkg_valid_i;
  logic                            pkg_ready_o;
  wired_isa_pkg::op_e              pkg_op_i;
  wired_isa_pkg::reg_id_t          pkg_rd_i;
  wired_isa_pkg::reg_id_t          pkg_rs1_i;
  wired_isa_pkg::reg_id_t          pkg_rs2_i;
  logic [IMM_W-1:0]                pkg_imm_i;
  logic                            commit_valid_o;
  wired_isa_pkg::reg_id_t          commit_rd_o;
  wired_isa_pkg::data_t            commit_data_o;

  logic [31:0]                     lfsr_state;
  wired_isa_pkg::data_t            model_regs [32];
  wired_isa_pkg::reg_id_t          exp_rd_q [$];
  wired_isa_pkg::data_t            exp_data_q [$];
  int                              accepted_cnt;
  int                              commit_cnt;
  int                              stall_cycles;

  wired_backend #(
    .ROB_DEPTH(ROB_DEPTH),
    .MUL_LATENCY(MUL_LATENCY)
  ) wired_backend_i (
    .clk(clk),
    .rst_n(rst_n),
    .pkg_valid_i(pkg_valid_i),
    .pkg_ready_o(pkg_ready_o),
    .pkg_op_i(pkg_op_i),
    .pkg_rd_i(pkg_rd_i),
    .pkg_rs1_i(pkg_rs1_i),
    .pkg_rs2_i(pkg_rs2_i),
    .pkg_imm_i(pkg_imm_i),
    .commit_valid_o(commit_valid_o),
    .commit_rd_o(commit_rd_o),
    .commit_data_o(commit_data_o)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on the first error");
  endtask

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic wired_isa_pkg::data_t model_result(input wired_isa_pkg::op_e op,
                                                        input wired_isa_pkg::data_t a,
                                                        input wired_isa_pkg::data_t b);
    case (op)
      wired_isa_pkg::OP_ADD:  return a + b;
      wired_isa_pkg::OP_ADDI: return a + b;
      wired_isa_pkg::OP_SUB:  return a - b;
      wired_isa_pkg::OP_AND:  return a & b;
      wired_isa_pkg::OP_OR:   return a | b;
      wired_isa_pkg::OP_XOR:  return a ^ b;
      wired_isa_pkg::OP_MUL:  return a * b;
      default:                return '0;
    endcase
  endfunction

  task automatic make_packet(input int mode);
    logic [2:0] op_bits;
    op_bits = 3'(take_bits(3));
    if (mode == MODE_MUL) begin
      // mostly multiplies with an occasional ADDI to keep values alive
      op_bits   = (op_bits == 3'd0) ? 3'(wired_isa_pkg::OP_ADDI) : 3'(wired_isa_pkg::OP_MUL);
      pkg_rd_i  = 5'(1 + take_bits(1));
      pkg_rs1_i = 5'(1 + take_bits(1));
      pkg_rs2_i = 5'(take_bits(2));
      if (pkg_rs2_i == 5'd0) begin
        pkg_rs2_i = 5'd3;
      end
    end else if (mode == MODE_DEP) begin
      pkg_rd_i  = 5'(take_bits(2));
      pkg_rs1_i = 5'(take_bits(2));
      pkg_rs2_i = 5'(take_bits(2));
    end else begin
      pkg_rd_i  = 5'(take_bits(5));
      pkg_rs1_i = 5'(take_bits(5));
      pkg_rs2_i = 5'(take_bits(5));
    end
    if (op_bits == 3'd7) begin
      op_bits = 3'(wired_isa_pkg::OP_MUL);
    end
    pkg_op_i  = wired_isa_pkg::op_e'(op_bits);
    pkg_imm_i = IMM_W'(take_bits(IMM_W));
  endtask

  // in-order reference executes at acceptance and queues the expected commit
  task automatic accept_packet();
    wired_isa_pkg::data_t a;
    wired_isa_pkg::data_t b;
    wired_isa_pkg::data_t res;
    a = (pkg_rs1_i == 5'd0) ? '0 : model_regs[pkg_rs1_i];
    if (pkg_op_i == wired_isa_pkg::OP_ADDI) begin
      b = {{(32 - IMM_W){pkg_imm_i[IMM_W-1]}}, pkg_imm_i};
    end else begin
      b = (pkg_rs2_i == 5'd0) ? '0 : model_regs[pkg_rs2_i];
    end
    res = model_result(pkg_op_i, a, b);
    exp_rd_q.push_back(pkg_rd_i);
    exp_data_q.push_back(res);
    if (pkg_rd_i != 5'd0) begin
      model_regs[pkg_rd_i] = res;
    end
    accepted_cnt++;
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      assert (pkg_ready_o === 1'b1) else begin
        $display("ERROR: pkg_ready_o = %h while idle, expected 1", pkg_ready_o);
        abort_run();
      end
      assert (commit_valid_o === 1'b0) else begin
        $display("ERROR: commit_valid_o = %h before any packet, expected 0", commit_valid_o);
        abort_run();
      end
    end
  endtask

  task automatic run_phase(input int mode, input int count);
    int sent;
    logic holding;
    logic [1:0] gap;
    sent = 0;
    holding = 1'b0;
    while (sent < count) begin
      @(posedge clk);
      #1;
      if (!holding) begin
        gap = 2'(take_bits(2));
        if (mode != MODE_DEP && gap == 2'd0) begin
          pkg_valid_i = 1'b0;
        end else begin
          make_packet(mode);
          pkg_valid_i = 1'b1;
        end
      end
      @(negedge clk);
      if (pkg_valid_i && pkg_ready_o) begin
        accept_packet();
        sent++;
        holding = 1'b0;
      end else if (pkg_valid_i) begin
        stall_cycles++;
        holding = 1'b1;
      end
    end
  endtask

  // commit checker
  always @(negedge clk) begin
    if (rst_n && commit_valid_o === 1'b1) begin
      assert (exp_rd_q.size() > 0) else begin
        $display("a commit appeared with no instruction outstanding");
        abort_run();
      end
      assert (commit_rd_o == exp_rd_q[0]) else begin
        $display("ERROR: commit_rd_o = %h, expected %h", commit_rd_o, exp_rd_q[0]);
        abort_run();
      end
      assert (commit_data_o == exp_data_q[0]) else begin
        $display("ERROR: commit_data_o = %h, expected %h (rd %h)",
                 commit_data_o, exp_data_q[0], exp_rd_q[0]);
        abort_run();
      end
      void'(exp_rd_q.pop_front());
      void'(exp_data_q.pop_front());
      commit_cnt++;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: not all accepted packets committed in time");
    abort_run();
  end

  initial begin
    int stalls_before_mul;
    lfsr_state   = 32'h3670ae9d;
    accepted_cnt = 0;
    commit_cnt   = 0;
    stall_cycles = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    rst_n       = 1'b0;
    pkg_valid_i = 1'b0;
    pkg_op_i    = wired_isa_pkg::OP_ADD;
    pkg_rd_i    = '0;
    pkg_rs1_i   = '0;
    pkg_rs2_i   = '0;
    pkg_imm_i   = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;

    check_idle(8);
    run_phase(MODE_MIXED, N_MIXED);
    run_phase(MODE_DEP, N_DEP);
    stalls_before_mul = stall_cycles;
    run_phase(MODE_MUL, N_MUL);
    assert (stall_cycles > stalls_before_mul) else begin
      $display("the multiply chains never stalled the frontend");
      abort_run();
    end

    @(posedge clk);
    #1 pkg_valid_i = 1'b0;
    while (commit_cnt != accepted_cnt) begin
      @(negedge clk);
    end
    // any late extra commit trips the checker here
    repeat (10) @(negedge clk);
    if (exp_rd_q.size() == 0 && commit_cnt == accepted_cnt) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("commit count %0d does not match accepted count %0d",
               commit_cnt, accepted_cnt);
      abort_run();
    end
  end

endmodule

`default_nettype wire

/* wired_lite.f */
wired_isa_pkg.sv
wired_core_pkg.sv
wired_regfile.sv
wired_rename.sv
wired_dispatch.sv
wired_exec.sv
wired_rob.sv
wired_backend.sv
tb_wired_backend.sv

/* run.sh */
#!/bin/sh
# builds the backend testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  -f wired_lite.f --top-module tb_wired_backend \
  --Mdir obj_dir -o tb_wired_backend
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_wired_backend
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi
exit 0
